/* source/sched_pkg.sv */
package sched_pkg;

  // Sizes
  localparam int interface_count  = 3;
  localparam int interface_width  = 2;
  localparam int core_count       = 4;
  localparam int core_id_width    = 2;
  localparam int slot_count       = 8;
  // Slot numbers run 1 to 8, counts 0 to 8
  localparam int slot_width       = 4;
  localparam int hash_width       = 32;
  localparam int hash_queue_depth = 8;

  // Host command word fields
  localparam int cmd_wr_bit     = 31;
  localparam int cmd_sched_bit  = 30;
  localparam int cmd_addr_lsb   = 27;
  localparam int cmd_addr_width = 3;

  // Scheduler register map
  localparam logic [cmd_addr_width-1:0] addr_income_cores  = 3'd0;
  localparam logic [cmd_addr_width-1:0] addr_enabled_cores = 3'd1;
  localparam logic [cmd_addr_width-1:0] addr_slot_count    = 3'd2;
  localparam logic [cmd_addr_width-1:0] addr_slot_flush    = 3'd3;
  localparam logic [cmd_addr_width-1:0] addr_enabled_ints  = 3'd5;
  localparam logic [cmd_addr_width-1:0] addr_drop_count    = 3'd7;

  localparam logic [31:0] unmapped_read_value = 32'hfefe_fefe;

endpackage

/* source/host_cmd_regs.sv */
`timescale 1ns/1ps

module host_cmd_regs (
  input  logic                                                    clk,
  input  logic                                                    rst_r,
  input  logic [31:0]                                             host_cmd,
  input  logic [31:0]                                             host_cmd_wr_data,
  input  logic                                                    host_cmd_valid,
  input  logic [sched_pkg::core_count*sched_pkg::slot_width-1:0]  slot_counts,
  input  logic [sched_pkg::interface_count*32-1:0]                drop_counts,
  output logic [31:0]                                             host_cmd_rd_data,
  output logic [sched_pkg::core_count-1:0]                        income_cores,
  output logic [sched_pkg::interface_count-1:0]                   enabled_ints,
  output logic [sched_pkg::core_count-1:0]                        slot_flush
);

  logic [sched_pkg::core_count-1:0]      enabled_cores;
  logic [sched_pkg::cmd_addr_width-1:0]  addr_r;
  logic [31:0]                           wr_data_r;
  logic                                  wr_valid_r;
  logic [sched_pkg::core_id_width-1:0]   rd_core_r;
  logic [sched_pkg::interface_width-1:0] rd_int_r;
  logic [sched_pkg::core_count-1:0]      wr_cores;

  // First stage, capture the command word
  always_ff @(posedge clk) begin
    addr_r    <= host_cmd[sched_pkg::cmd_addr_lsb +: sched_pkg::cmd_addr_width];
    wr_data_r <= host_cmd_wr_data;
    rd_core_r <= host_cmd[sched_pkg::core_id_width-1:0];
    rd_int_r  <= host_cmd[sched_pkg::interface_width-1:0];
    if (rst_r) begin
      wr_valid_r <= 1'b0;
    end else begin
      wr_valid_r <= host_cmd_valid && host_cmd[sched_pkg::cmd_wr_bit] &&
                    host_cmd[sched_pkg::cmd_sched_bit];
    end
  end

  assign wr_cores = wr_data_r[sched_pkg::core_count-1:0];

  // Second stage, apply scheduler writes
  always_ff @(posedge clk) begin
    if (rst_r) begin
      income_cores  <= '0;
      enabled_cores <= '0;
      enabled_ints  <= '0;
      slot_flush    <= '0;
    end else begin
      slot_flush <= '0;
      if (wr_valid_r) begin
        case (addr_r)
          // A disabled core never takes incoming traffic
          sched_pkg::addr_income_cores: income_cores <= wr_cores & enabled_cores;
          sched_pkg::addr_enabled_cores: begin
            enabled_cores <= wr_cores;
            income_cores  <= income_cores & wr_cores;
          end
          sched_pkg::addr_slot_flush:   slot_flush <= wr_cores;
          sched_pkg::addr_enabled_ints:
            enabled_ints <= wr_data_r[sched_pkg::interface_count-1:0];
          default: ;
        endcase
      end
    end
  end

  // Read mux, registered on the second stage
  always_ff @(posedge clk) begin
    if (rst_r) begin
      host_cmd_rd_data <= '0;
    end else begin
      case (addr_r)
        sched_pkg::addr_income_cores:  host_cmd_rd_data <= 32'(income_cores);
        sched_pkg::addr_enabled_cores: host_cmd_rd_data <= 32'(enabled_cores);
        sched_pkg::addr_slot_count:
          host_cmd_rd_data <= 32'(slot_counts[rd_core_r*sched_pkg::slot_width +:
                                              sched_pkg::slot_width]);
        sched_pkg::addr_slot_flush:    host_cmd_rd_data <= 32'(slot_flush);
        sched_pkg::addr_enabled_ints:  host_cmd_rd_data <= 32'(enabled_ints);
        sched_pkg::addr_drop_count: begin
          if (rd_int_r < sched_pkg::interface_count)
            host_cmd_rd_data <= drop_counts[rd_int_r*32 +: 32];
          else
            host_cmd_rd_data <= '0;
        end
        default: host_cmd_rd_data <= sched_pkg::unmapped_read_value;
      endcase
    end
  end

endmodule

/* source/slot_keeper.sv */
`timescale 1ns/1ps

module slot_keeper (
  input  logic                             clk,
  input  logic                             rst_r,
  input  logic                             flush,
  input  logic                             msg_valid,
  input  logic                             msg_init,
  input  logic [sched_pkg::slot_width-1:0] msg_slot,
  input  logic                             pop,
  output logic [sched_pkg::slot_width-1:0] head_slot,
  output logic                             slot_valid,
  output logic [sched_pkg::slot_width-1:0] slot_count
);

  logic [sched_pkg::slot_width-1:0]         slots [sched_pkg::slot_count];
  logic [$clog2(sched_pkg::slot_count)-1:0] rd_ptr;
  logic [$clog2(sched_pkg::slot_count)-1:0] wr_ptr;
  logic                                     msg_valid_r;
  logic                                     msg_init_r;
  logic [sched_pkg::slot_width-1:0]         msg_slot_r;
  logic                                     full;
  logic                                     do_push;
  logic                                     do_pop;
  logic                                     do_init;
  logic                                     enq_err;

  // Slot message held one cycle before it touches the list
  always_ff @(posedge clk) begin
    msg_init_r <= msg_init;
    msg_slot_r <= msg_slot;
    if (rst_r)
      msg_valid_r <= 1'b0;
    else
      msg_valid_r <= msg_valid;
  end

  assign full       = (slot_count == sched_pkg::slot_width'(sched_pkg::slot_count));
  assign slot_valid = (slot_count != '0);
  assign head_slot  = slots[rd_ptr];
  assign do_pop     = pop && slot_valid;
  assign do_init    = msg_valid_r && msg_init_r;
  assign do_push    = msg_valid_r && !msg_init_r && (!full || do_pop);

  // Init writes the whole ring, only the first n entries count
  always_ff @(posedge clk) begin
    if (do_init) begin
      for (int i = 0; i < sched_pkg::slot_count; i++)
        slots[i] <= sched_pkg::slot_width'(i + 1);
    end else if (do_push) begin
      slots[wr_ptr] <= msg_slot_r;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      slot_count <= '0;
    end else if (do_init) begin
      rd_ptr     <= '0;
      wr_ptr     <= msg_slot_r[$clog2(sched_pkg::slot_count)-1:0];
      slot_count <= msg_slot_r;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        slot_count <= slot_count + 1'b1;
      else if (do_pop && !do_push)
        slot_count <= slot_count - 1'b1;
    end
  end

  // Sticky, a returned slot was lost on a full list
  always_ff @(posedge clk) begin
    if (rst_r)
      enq_err <= 1'b0;
    else
      enq_err <= enq_err || (msg_valid_r && !msg_init_r && full && !do_pop);
  end

endmodule

/* source/hash_queue.sv */
`timescale 1ns/1ps

module hash_queue (
  input  logic                             clk,
  input  logic                             rst_r,
  input  logic                             enable,
  input  logic [sched_pkg::hash_width-1:0] in_hash,
  input  logic                             in_valid,
  output logic                             in_ready,
  input  logic                             pop,
  output logic [sched_pkg::hash_width-1:0] head,
  output logic                             head_valid
);

  logic [sched_pkg::hash_width-1:0]               mem [sched_pkg::hash_queue_depth];
  logic [$clog2(sched_pkg::hash_queue_depth)-1:0] rd_ptr;
  logic [$clog2(sched_pkg::hash_queue_depth)-1:0] wr_ptr;
  logic [$clog2(sched_pkg::hash_queue_depth+1)-1:0] count;
  logic                                           do_push;
  logic                                           do_pop;

  assign in_ready   = enable && (count != sched_pkg::hash_queue_depth);
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];
  assign do_push    = in_valid && in_ready;
  assign do_pop     = pop && head_valid;

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= in_hash;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

/* source/desc_allocator.sv */
`timescale 1ns/1ps

module desc_allocator (
  input  logic                                                         clk,
  input  logic                                                         rst_r,
  input  logic [sched_pkg::interface_count*sched_pkg::hash_width-1:0]  heads,
  input  logic [sched_pkg::interface_count-1:0]                        head_valid,
  input  logic [sched_pkg::interface_count-1:0]                        almost_full,
  input  logic [sched_pkg::core_count-1:0]                             income_cores,
  input  logic [sched_pkg::core_count*sched_pkg::slot_width-1:0]       head_slots,
  input  logic [sched_pkg::core_count-1:0]                             slot_valid,
  input  logic [sched_pkg::interface_count-1:0]                        desc_ready,
  output logic [sched_pkg::interface_count-1:0]                        hash_pop,
  output logic [sched_pkg::core_count-1:0]                             slot_pop,
  output logic                                                         drop_pulse,
  output logic [sched_pkg::interface_width-1:0]                        drop_port,
  output logic [sched_pkg::interface_count-1:0]                        desc_valid,
  output logic [sched_pkg::interface_count-1:0]                        desc_drop,
  output logic [sched_pkg::interface_count*sched_pkg::hash_width-1:0]  desc_hash,
  output logic [sched_pkg::interface_count*sched_pkg::core_id_width-1:0] desc_core,
  output logic [sched_pkg::interface_count*sched_pkg::slot_width-1:0]  desc_slot
);

  logic [sched_pkg::interface_count-1:0] req;
  logic [sched_pkg::interface_count-1:0] sel_mask;
  logic                                  grant_v;
  logic [sched_pkg::interface_width-1:0] grant_idx;
  logic [sched_pkg::interface_width-1:0] rr_ptr;
  logic                                  sel_v_r;
  logic [sched_pkg::interface_width-1:0] sel_idx_r;
  logic [sched_pkg::core_id_width-1:0]   sel_core_r;
  logic [sched_pkg::hash_width-1:0]      sel_hash;
  logic                                  slot_ok;
  logic                                  do_alloc;
  logic                                  do_drop;

  // Interface held in stage 2 must sit out this round
  always_comb begin
    for (int i = 0; i < sched_pkg::interface_count; i++)
      sel_mask[i] = sel_v_r && (sel_idx_r == i);
  end

  assign req = head_valid & ~desc_valid & ~sel_mask;

  // Round robin, search starts at rr_ptr
  always_comb begin
    int unsigned idx;
    grant_v   = 1'b0;
    grant_idx = '0;
    for (int k = 0; k < sched_pkg::interface_count; k++) begin
      idx = (rr_ptr + k) % sched_pkg::interface_count;
      if (!grant_v && req[idx]) begin
        grant_v   = 1'b1;
        grant_idx = idx[sched_pkg::interface_width-1:0];
      end
    end
  end

  // Stage 1 registers, destination core taken from the low hash bits
  always_ff @(posedge clk) begin
    if (rst_r) begin
      sel_v_r <= 1'b0;
      rr_ptr  <= '0;
    end else begin
      sel_v_r <= grant_v;
      if (grant_v) begin
        if (grant_idx == sched_pkg::interface_count - 1)
          rr_ptr <= '0;
        else
          rr_ptr <= grant_idx + 1'b1;
      end
    end
    sel_idx_r  <= grant_idx;
    sel_core_r <= heads[grant_idx*sched_pkg::hash_width +: sched_pkg::core_id_width];
  end

  // Stage 2 allocate or drop
  assign sel_hash   = heads[sel_idx_r*sched_pkg::hash_width +: sched_pkg::hash_width];
  assign slot_ok    = income_cores[sel_core_r] && slot_valid[sel_core_r];
  assign do_alloc   = sel_v_r && slot_ok;
  assign do_drop    = sel_v_r && !slot_ok && almost_full[sel_idx_r];
  assign drop_pulse = do_drop;
  assign drop_port  = sel_idx_r;

  always_comb begin
    for (int i = 0; i < sched_pkg::interface_count; i++)
      hash_pop[i] = (do_alloc || do_drop) && (sel_idx_r == i);
    for (int c = 0; c < sched_pkg::core_count; c++)
      slot_pop[c] = do_alloc && (sel_core_r == c);
  end

  // Output descriptor registers, one per interface
  always_ff @(posedge clk) begin
    for (int i = 0; i < sched_pkg::interface_count; i++) begin
      if (rst_r)
        desc_valid[i] <= 1'b0;
      else if (hash_pop[i])
        desc_valid[i] <= 1'b1;
      else if (desc_ready[i])
        desc_valid[i] <= 1'b0;

      if (hash_pop[i]) begin
        desc_drop[i] <= do_drop;
        desc_hash[i*sched_pkg::hash_width +: sched_pkg::hash_width] <= sel_hash;
        desc_core[i*sched_pkg::core_id_width +: sched_pkg::core_id_width] <= sel_core_r;
        // Drop descriptors carry slot 0
        if (do_alloc)
          desc_slot[i*sched_pkg::slot_width +: sched_pkg::slot_width] <=
            head_slots[sel_core_r*sched_pkg::slot_width +: sched_pkg::slot_width];
        else
          desc_slot[i*sched_pkg::slot_width +: sched_pkg::slot_width] <= '0;
      end
    end
  end

endmodule

/* source/drop_counter.sv */
`timescale 1ns/1ps

module drop_counter (
  input  logic                                  clk,
  input  logic                                  rst_r,
  input  logic                                  drop_pulse,
  input  logic [sched_pkg::interface_width-1:0] drop_port,
  output logic [sched_pkg::interface_count*32-1:0] drop_counts
);

  always_ff @(posedge clk) begin
    if (rst_r) begin
      drop_counts <= '0;
    end else if (drop_pulse) begin
      for (int i = 0; i < sched_pkg::interface_count; i++) begin
        if (drop_port == i)
          drop_counts[i*32 +: 32] <= drop_counts[i*32 +: 32] + 32'd1;
      end
    end
  end

endmodule

/* source/flow_scheduler.sv */
`timescale 1ns/1ps

module flow_scheduler (
  input  logic                                                           clk,
  input  logic                                                           rst_r,
  input  logic [sched_pkg::interface_count*sched_pkg::hash_width-1:0]    hash_data,
  input  logic [sched_pkg::interface_count-1:0]                          hash_valid,
  output logic [sched_pkg::interface_count-1:0]                          hash_ready,
  input  logic [sched_pkg::interface_count-1:0]                          almost_full,
  input  logic                                                           slot_msg_valid,
  input  logic                                                           slot_msg_init,
  input  logic [sched_pkg::core_id_width-1:0]                            slot_msg_core,
  input  logic [sched_pkg::slot_width-1:0]                               slot_msg_slot,
  input  logic [31:0]                                                    host_cmd,
  input  logic [31:0]                                                    host_cmd_wr_data,
  input  logic                                                           host_cmd_valid,
  output logic [31:0]                                                    host_cmd_rd_data,
  output logic [sched_pkg::interface_count-1:0]                          desc_valid,
  output logic [sched_pkg::interface_count-1:0]                          desc_drop,
  output logic [sched_pkg::interface_count*sched_pkg::hash_width-1:0]    desc_hash,
  output logic [sched_pkg::interface_count*sched_pkg::core_id_width-1:0] desc_core,
  output logic [sched_pkg::interface_count*sched_pkg::slot_width-1:0]    desc_slot,
  input  logic [sched_pkg::interface_count-1:0]                          desc_ready
);

  logic [sched_pkg::interface_count*sched_pkg::hash_width-1:0] heads;
  logic [sched_pkg::interface_count-1:0]                       head_valid;
  logic [sched_pkg::interface_count-1:0]                       hash_pop;
  logic [sched_pkg::core_count*sched_pkg::slot_width-1:0]      head_slots;
  logic [sched_pkg::core_count*sched_pkg::slot_width-1:0]      slot_counts;
  logic [sched_pkg::core_count-1:0]                            slot_valid;
  logic [sched_pkg::core_count-1:0]                            slot_pop;
  logic [sched_pkg::core_count-1:0]                            income_cores;
  logic [sched_pkg::core_count-1:0]                            slot_flush;
  logic [sched_pkg::interface_count-1:0]                       enabled_ints;
  logic                                                        drop_pulse;
  logic [sched_pkg::interface_width-1:0]                       drop_port;
  logic [sched_pkg::interface_count*32-1:0]                    drop_counts;

  for (genvar i = 0; i < sched_pkg::interface_count; i++) begin : g_queue
    hash_queue u_queue (
      .clk        (clk),
      .rst_r      (rst_r),
      .enable     (enabled_ints[i]),
      .in_hash    (hash_data[i*sched_pkg::hash_width +: sched_pkg::hash_width]),
      .in_valid   (hash_valid[i]),
      .in_ready   (hash_ready[i]),
      .pop        (hash_pop[i]),
      .head       (heads[i*sched_pkg::hash_width +: sched_pkg::hash_width]),
      .head_valid (head_valid[i])
    );
  end

  // Slot messages are steered by core index
  for (genvar c = 0; c < sched_pkg::core_count; c++) begin : g_keeper
    slot_keeper u_keeper (
      .clk        (clk),
      .rst_r      (rst_r),
      .flush      (slot_flush[c]),
      .msg_valid  (slot_msg_valid && (slot_msg_core == c)),
      .msg_init   (slot_msg_init),
      .msg_slot   (slot_msg_slot),
      .pop        (slot_pop[c]),
      .head_slot  (head_slots[c*sched_pkg::slot_width +: sched_pkg::slot_width]),
      .slot_valid (slot_valid[c]),
      .slot_count (slot_counts[c*sched_pkg::slot_width +: sched_pkg::slot_width])
    );
  end

  desc_allocator u_allocator (
    .clk          (clk),
    .rst_r        (rst_r),
    .heads        (heads),
    .head_valid   (head_valid),
    .almost_full  (almost_full),
    .income_cores (income_cores),
    .head_slots   (head_slots),
    .slot_valid   (slot_valid),
    .desc_ready   (desc_ready),
    .hash_pop     (hash_pop),
    .slot_pop     (slot_pop),
    .drop_pulse   (drop_pulse),
    .drop_port    (drop_port),
    .desc_valid   (desc_valid),
    .desc_drop    (desc_drop),
    .desc_hash    (desc_hash),
    .desc_core    (desc_core),
    .desc_slot    (desc_slot)
  );

  drop_counter u_drop_counter (
    .clk         (clk),
    .rst_r       (rst_r),
    .drop_pulse  (drop_pulse),
    .drop_port   (drop_port),
    .drop_counts (drop_counts)
  );

  host_cmd_regs u_regs (
    .clk              (clk),
    .rst_r            (rst_r),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .slot_counts      (slot_counts),
    .drop_counts      (drop_counts),
    .host_cmd_rd_data (host_cmd_rd_data),
    .income_cores     (income_cores),
    .enabled_ints     (enabled_ints),
    .slot_flush       (slot_flush)
  );

endmodule

/* tests/tb_flow_scheduler.sv */
`timescale 1ns/1ps

module tb_flow_scheduler;

  localparam int clk_period = 8;
  // Rough cycle count of all tests together
  localparam int test_cycles = 1000;
  localparam int n_int = sched_pkg::interface_count;
  localparam int hw = sched_pkg::hash_width;

  logic                     clk = 1'b0;
  logic                     rst_r;
  logic [n_int*hw-1:0]      hash_data;
  logic [n_int-1:0]         hash_valid;
  logic [n_int-1:0]         hash_ready;
  logic [n_int-1:0]         almost_full;
  logic                     slot_msg_valid;
  logic                     slot_msg_init;
  logic [1:0]               slot_msg_core;
  logic [3:0]               slot_msg_slot;
  logic [31:0]              host_cmd;
  logic [31:0]              host_cmd_wr_data;
  logic                     host_cmd_valid;
  logic [31:0]              host_cmd_rd_data;
  logic [n_int-1:0]         desc_valid;
  logic [n_int-1:0]         desc_drop;
  logic [n_int*hw-1:0]      desc_hash;
  logic [n_int*2-1:0]       desc_core;
  logic [n_int*4-1:0]       desc_slot;
  logic [n_int-1:0]         desc_ready;

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  logic [n_int-1:0] prev_valid;
  logic [n_int-1:0] ready_at_edge;
  logic [hw-1:0]    held_hash [n_int];
  logic [6:0]       held_fields [n_int];
  // Reference model state
  logic [31:0] sent_q [n_int][$];
  logic [3:0]  slot_q [4][$];
  logic [3:0]  income_m;
  logic [31:0] drops_m [n_int];

  always #(clk_period / 2) clk = ~clk;

  flow_scheduler u_dut (
    .clk              (clk),
    .rst_r            (rst_r),
    .hash_data        (hash_data),
    .hash_valid       (hash_valid),
    .hash_ready       (hash_ready),
    .almost_full      (almost_full),
    .slot_msg_valid   (slot_msg_valid),
    .slot_msg_init    (slot_msg_init),
    .slot_msg_core    (slot_msg_core),
    .slot_msg_slot    (slot_msg_slot),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .host_cmd_rd_data (host_cmd_rd_data),
    .desc_valid       (desc_valid),
    .desc_drop        (desc_drop),
    .desc_hash        (desc_hash),
    .desc_core        (desc_core),
    .desc_slot        (desc_slot),
    .desc_ready       (desc_ready)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // Drop flag, core and slot of one interface's descriptor
  function automatic logic [6:0] desc_fields(input int port);
    return {desc_drop[port], desc_core[port*2 +: 2], desc_slot[port*4 +: 4]};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("ERROR at %0t ns: %s", $time, what);
    end
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    @(negedge clk);
    host_cmd = (32'd1 << sched_pkg::cmd_wr_bit) | (32'd1 << sched_pkg::cmd_sched_bit) |
               (32'(addr) << sched_pkg::cmd_addr_lsb);
    host_cmd_wr_data = data;
    host_cmd_valid = 1'b1;
    @(negedge clk);
    host_cmd_valid = 1'b0;
    host_cmd = '0;
  endtask

  // Read data shows up two cycles after the address
  task automatic read_check(input logic [2:0] addr, input int sel, input logic [31:0] expected,
                            input string name);
    @(negedge clk);
    host_cmd = (32'd1 << sched_pkg::cmd_sched_bit) | (32'(addr) << sched_pkg::cmd_addr_lsb) |
               32'(sel);
    @(negedge clk);
    @(negedge clk);
    check_eq($sformatf("%s[%0d]", name, sel), expected, host_cmd_rd_data);
  endtask

  task automatic send_slot_msg(input logic init, input int core, input logic [3:0] slot);
    @(negedge clk);
    slot_msg_valid = 1'b1;
    slot_msg_init = init;
    slot_msg_core = core[1:0];
    slot_msg_slot = slot;
    @(negedge clk);
    slot_msg_valid = 1'b0;
    if (init) begin
      slot_q[core].delete();
      for (int k = 1; k <= int'(slot); k++)
        slot_q[core].push_back(4'(k));
    end else if (slot_q[core].size() < sched_pkg::slot_count) begin
      // A return into a full list is lost
      slot_q[core].push_back(slot);
    end
  endtask

  task automatic send_hash(input int port, input logic [31:0] h);
    @(negedge clk);
    hash_data[port*hw +: hw] = h;
    hash_valid[port] = 1'b1;
    while (!hash_ready[port])
      @(negedge clk);
    // Transfer happens on the coming rising edge
    sent_q[port].push_back(h);
    @(negedge clk);
    hash_valid[port] = 1'b0;
  endtask

  task automatic send_burst(input int port, input int n);
    for (int k = 0; k < n; k++)
      send_hash(port, rand_bits(32));
  endtask

  task automatic wait_drain();
    while (sent_q[0].size() + sent_q[1].size() + sent_q[2].size() != 0)
      @(negedge clk);
    repeat (3) @(negedge clk);
  endtask

  task automatic check_new_desc(input int port);
    logic [31:0] h;
    logic [1:0]  core;
    logic        drop;
    logic [3:0]  slot;
    check_true(sent_q[port].size() != 0,
               $sformatf("descriptor on interface %0d without a sent hash", port));
    if (sent_q[port].size() != 0) begin
      h = sent_q[port].pop_front();
      core = h[1:0];
      drop = !(income_m[core] && slot_q[core].size() != 0);
      slot = 4'd0;
      if (drop)
        drops_m[port]++;
      else
        slot = slot_q[core].pop_front();
      check_eq($sformatf("desc_hash[%0d]", port), h, desc_hash[port*hw +: hw]);
      check_eq($sformatf("desc_core[%0d]", port), 32'(core), 32'(desc_core[port*2 +: 2]));
      check_eq($sformatf("desc_drop[%0d]", port), 32'(drop), 32'(desc_drop[port]));
      check_eq($sformatf("desc_slot[%0d]", port), 32'(slot), 32'(desc_slot[port*4 +: 4]));
    end
  endtask

  always @(posedge clk) ready_at_edge <= desc_ready;

  // Descriptor monitor, a new one follows a cycle with valid low
  always @(negedge clk) begin
    if (rst_r) begin
      prev_valid = '0;
    end else begin
      for (int i = 0; i < n_int; i++) begin
        if (desc_valid[i] && !prev_valid[i]) begin
          check_new_desc(i);
        end else if (prev_valid[i] && !ready_at_edge[i]) begin
          check_eq($sformatf("desc_valid[%0d]", i), 32'd1, 32'(desc_valid[i]));
          check_eq($sformatf("desc_hash[%0d]", i), held_hash[i], desc_hash[i*hw +: hw]);
          check_eq($sformatf("desc_drop_core_slot[%0d]", i), 32'(held_fields[i]),
                   32'(desc_fields(i)));
        end
        held_hash[i] = desc_hash[i*hw +: hw];
        held_fields[i] = desc_fields(i);
      end
      prev_valid = desc_valid;
    end
  end

  initial begin
    lfsr = 32'hb79e;
    errors = 0;
    checks = 0;
    income_m = '0;
    for (int i = 0; i < n_int; i++)
      drops_m[i] = '0;
    rst_r = 1'b1;
    hash_data = '0;
    hash_valid = '0;
    almost_full = '0;
    slot_msg_valid = 1'b0;
    slot_msg_init = 1'b0;
    slot_msg_core = '0;
    slot_msg_slot = '0;
    host_cmd = '0;
    host_cmd_wr_data = '0;
    host_cmd_valid = 1'b0;
    desc_ready = '1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_r = 1'b0;

    // Reset state
    check_eq("desc_valid", 32'd0, 32'(desc_valid));
    check_eq("hash_ready", 32'd0, 32'(hash_ready));
    for (int c = 0; c < 4; c++)
      read_check(sched_pkg::addr_slot_count, c, 32'd0, "slot_count");
    for (int i = 0; i < n_int; i++)
      read_check(sched_pkg::addr_drop_count, i, 32'd0, "drop_count");
    read_check(sched_pkg::addr_income_cores, 0, 32'd0, "income_cores");
    read_check(sched_pkg::addr_enabled_cores, 0, 32'd0, "enabled_cores");
    read_check(sched_pkg::addr_slot_flush, 0, 32'd0, "slot_flush");
    read_check(sched_pkg::addr_enabled_ints, 0, 32'd0, "enabled_ints");

    // Register writes, income is masked by enabled cores
    write_reg(sched_pkg::addr_enabled_cores, 32'h3);
    read_check(sched_pkg::addr_enabled_cores, 0, 32'h3, "enabled_cores");
    write_reg(sched_pkg::addr_income_cores, 32'hf);
    read_check(sched_pkg::addr_income_cores, 0, 32'h3, "income_cores");
    write_reg(sched_pkg::addr_enabled_cores, 32'hf);
    write_reg(sched_pkg::addr_income_cores, 32'hf);
    income_m = 4'hf;
    read_check(sched_pkg::addr_income_cores, 0, 32'hf, "income_cores");
    read_check(3'd4, 0, sched_pkg::unmapped_read_value, "unmapped");
    read_check(3'd6, 0, sched_pkg::unmapped_read_value, "unmapped");
    write_reg(sched_pkg::addr_enabled_ints, 32'h7);
    read_check(sched_pkg::addr_enabled_ints, 0, 32'h7, "enabled_ints");
    check_eq("hash_ready", 32'h7, 32'(hash_ready));

    // Init and returns fill each list, then random hashes
    for (int c = 0; c < 4; c++) begin
      send_slot_msg(1'b1, c, 4'd6);
      send_slot_msg(1'b0, c, 4'd7);
      send_slot_msg(1'b0, c, 4'd8);
    end
    // One more return overflows core 3
    send_slot_msg(1'b0, 3, 4'd5);
    repeat (2) @(negedge clk);
    check_eq("enq_err[3]", 32'd1, 32'(u_dut.g_keeper[3].u_keeper.enq_err));
    read_check(sched_pkg::addr_slot_count, 3, 32'(slot_q[3].size()), "slot_count");
    repeat (4) @(negedge clk);
    for (int k = 0; k < 8; k++)
      send_hash(int'(rand_bits(2) % 3), rand_bits(32));
    wait_drain();
    for (int c = 0; c < 4; c++)
      read_check(sched_pkg::addr_slot_count, c, 32'(slot_q[c].size()), "slot_count");

    // Flush core 0, then drop under almost-full, then wait for a return
    write_reg(sched_pkg::addr_slot_flush, 32'h1);
    slot_q[0].delete();
    read_check(sched_pkg::addr_slot_count, 0, 32'd0, "slot_count");
    almost_full = 3'b001;
    send_hash(0, rand_bits(30) << 2);
    wait_drain();
    read_check(sched_pkg::addr_drop_count, 0, drops_m[0], "drop_count");
    almost_full = '0;
    send_hash(1, rand_bits(30) << 2);
    repeat (20) @(negedge clk);
    check_eq("desc_valid[1]", 32'd0, 32'(desc_valid[1]));
    send_slot_msg(1'b0, 0, 4'd3);
    wait_drain();

    // Back-pressure on all interfaces, then release
    almost_full = '1;
    desc_ready = '0;
    fork
      send_burst(0, 10);
      send_burst(1, 10);
      send_burst(2, 10);
      begin
        repeat (60) @(negedge clk);
        check_eq("hash_ready", 32'd0, 32'(hash_ready));
        desc_ready = '1;
      end
    join
    wait_drain();
    for (int i = 0; i < n_int; i++)
      read_check(sched_pkg::addr_drop_count, i, drops_m[i], "drop_count");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial begin
    #(test_cycles * 20 * clk_period);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("Test FAILED");
    $finish;
  end

endmodule

/* flist.f */
source/sched_pkg.sv
source/host_cmd_regs.sv
source/slot_keeper.sv
source/hash_queue.sv
source/desc_allocator.sv
source/drop_counter.sv
source/flow_scheduler.sv
tests/tb_flow_scheduler.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the flow scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_flow_scheduler -f flist.f -o sim_flow_scheduler
./obj_dir/sim_flow_scheduler | tee sim.log

if grep -q "Test FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
